// ==== list.f ====
+incdir+testbench
common/texture_pkg.sv
design/window/row_buffer.sv
design/window/window_3x3.sv
design/lbp_code.sv
design/ni_code.sv
design/texture_top.sv
testbench/tb_texture.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f list.f --top-module tb_texture -o tb_texture

out=$(./obj_dir/tb_texture)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi

// ==== testbench/texture_ref.svh ====
`ifndef TEXTURE_REF_SVH
`define TEXTURE_REF_SVH

// neighbor b of the window centered at (r, c) of frame f
// bit order counterclockwise from east
function automatic logic [texture_pkg::PIX_W-1:0] nbr_pix(
    input int f,
    input int r,
    input int c,
    input int b
);
    int dr;
    int dc;
    case (b)
        0: begin dr = 0;  dc = 1;  end
        1: begin dr = -1; dc = 1;  end
        2: begin dr = -1; dc = 0;  end
        3: begin dr = -1; dc = -1; end
        4: begin dr = 0;  dc = -1; end
        5: begin dr = 1;  dc = -1; end
        6: begin dr = 1;  dc = 0;  end
        default: begin dr = 1; dc = 1; end
    endcase
    return img[f][r + dr][c + dc];
endfunction

// neighbor at or above the center pixel
function automatic logic [texture_pkg::CODE_W-1:0] lbp_ref(
    input int f,
    input int r,
    input int c
);
    logic [texture_pkg::CODE_W-1:0] code;
    for (int b = 0; b < texture_pkg::CODE_W; b++) begin
        code[b] = (nbr_pix(f, r, c, b) >= img[f][r][c]);
    end
    return code;
endfunction

// neighbor at or above the mean of the nine pixels
function automatic logic [texture_pkg::CODE_W-1:0] ni_ref(
    input int f,
    input int r,
    input int c
);
    logic [texture_pkg::CODE_W-1:0] code;
    logic [texture_pkg::SUM_W-1:0]  sum;
    sum = '0;
    for (int dr = -1; dr <= 1; dr++) begin
        for (int dc = -1; dc <= 1; dc++) begin
            sum = sum + texture_pkg::SUM_W'(img[f][r + dr][c + dc]);
        end
    end
    // mean without a divider, scale the neighbor instead
    for (int b = 0; b < texture_pkg::CODE_W; b++) begin
        code[b] = ((9 * int'(nbr_pix(f, r, c, b))) >= int'(sum));
    end
    return code;
endfunction

`endif

// ==== testbench/tb_texture.sv ====
module tb_texture;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_PIX = texture_pkg::ROWS * texture_pkg::COLS;
    localparam int FRAME_WIN = (texture_pkg::ROWS - 2) * (texture_pkg::COLS - 2);
    // three frames of up to four cycles per pixel at 4 ns
    localparam int WATCHDOG_NS = 3 * FRAME_PIX * 4 * 4 + 1000;

    logic                           clk = 1'b0;
    logic                           arst_n_i;
    logic [texture_pkg::PIX_W-1:0]  grayscale_i;
    logic                           done_i;
    logic [texture_pkg::CODE_W-1:0] lbp_code_o;
    logic [texture_pkg::CODE_W-1:0] ni_code_o;
    logic                           done_o;
    logic                           progress_done_o;

    // stored frames for the model
    logic [texture_pkg::PIX_W-1:0] img [3][texture_pkg::ROWS][texture_pkg::COLS];

    `include "texture_ref.svh"

    // expected codes in raster order of window centers
    logic [texture_pkg::CODE_W-1:0] exp_lbp_q [$];
    logic [texture_pkg::CODE_W-1:0] exp_ni_q [$];
    logic [texture_pkg::CODE_W-1:0] exp_lbp;
    logic [texture_pkg::CODE_W-1:0] exp_ni;
    int                             rd_idx;
    int                             pulse_cnt;
    int                             err_cnt;
    int                             test_cnt;

    // markers driven along with done_i
    logic  closes_win;
    logic  closes_last;
    logic  strobe_seen;
    logic  const_frame;
    string test_name;

    always #2 clk = ~clk;

    texture_top u_dut (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .grayscale_i     (grayscale_i),
        .done_i          (done_i),
        .lbp_code_o      (lbp_code_o),
        .ni_code_o       (ni_code_o),
        .done_o          (done_o),
        .progress_done_o (progress_done_o)
    );

    // advance the scoreboard head on every output window
    always @(posedge clk) begin
        if (done_o) begin
            rd_idx <= rd_idx + 1;
            if (rd_idx + 1 < exp_lbp_q.size()) begin
                exp_lbp <= exp_lbp_q[rd_idx + 1];
                exp_ni  <= exp_ni_q[rd_idx + 1];
            end
            pulse_cnt <= progress_done_o ? 0 : pulse_cnt + 1;
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
        !strobe_seen |-> (!done_o && !progress_done_o))
        else begin
            err_cnt++;
            $display("%s: output strobe raised before any pixel was sent", test_name);
        end

    a_done_timing: assert property (@(posedge clk) disable iff (!arst_n_i)
        done_o == $past(closes_win, 2))
        else begin
            err_cnt++;
            $display("FAIL %s done_o expected %b actual %b", test_name,
                     $sampled($past(closes_win, 2)), $sampled(done_o));
        end

    a_last_timing: assert property (@(posedge clk) disable iff (!arst_n_i)
        progress_done_o == $past(closes_last, 2))
        else begin
            err_cnt++;
            $display("FAIL %s progress_done_o expected %b actual %b", test_name,
                     $sampled($past(closes_last, 2)), $sampled(progress_done_o));
        end

    a_frame_count: assert property (@(posedge clk) disable iff (!arst_n_i)
        done_o |-> (progress_done_o == (pulse_cnt == FRAME_WIN - 1)))
        else begin
            err_cnt++;
            $display("%s: frame end strobe wrong at window %0d of a frame", test_name,
                     $sampled(pulse_cnt) + 1);
        end

    a_lbp: assert property (@(posedge clk) disable iff (!arst_n_i)
        done_o |-> (lbp_code_o == exp_lbp))
        else begin
            err_cnt++;
            $display("FAIL %s lbp_code_o expected %h actual %h", test_name,
                     $sampled(exp_lbp), $sampled(lbp_code_o));
        end

    a_ni: assert property (@(posedge clk) disable iff (!arst_n_i)
        done_o |-> (ni_code_o == exp_ni))
        else begin
            err_cnt++;
            $display("FAIL %s ni_code_o expected %h actual %h", test_name,
                     $sampled(exp_ni), $sampled(ni_code_o));
        end

    // flat patch sets every neighbor bit
    a_flat: assert property (@(posedge clk) disable iff (!arst_n_i)
        (done_o && const_frame) |-> ((lbp_code_o & ni_code_o) == '1))
        else begin
            err_cnt++;
            $display("FAIL %s flat codes expected ff_ff actual %h_%h", test_name,
                     $sampled(lbp_code_o), $sampled(ni_code_o));
        end

    task automatic send_frame(input int f, input bit gapped);
        int gap;
        bit last_pix;
        for (int r = 0; r < texture_pkg::ROWS; r++) begin
            for (int c = 0; c < texture_pkg::COLS; c++) begin
                last_pix = (r == texture_pkg::ROWS - 1) && (c == texture_pkg::COLS - 1);
                @(posedge clk);
                done_i      <= 1'b1;
                grayscale_i <= img[f][r][c];
                closes_win  <= (r >= 2) && (c >= 2);
                closes_last <= last_pix;
                strobe_seen <= 1'b1;
                // gaps only between pixels of a frame
                if (gapped && !last_pix) begin
                    gap = $urandom_range(3);
                    repeat (gap) begin
                        @(posedge clk);
                        done_i      <= 1'b0;
                        closes_win  <= 1'b0;
                        closes_last <= 1'b0;
                    end
                end
            end
        end
        @(posedge clk);
        done_i      <= 1'b0;
        closes_win  <= 1'b0;
        closes_last <= 1'b0;
    endtask

    // frame ends with the progress_done_o strobe
    task automatic wait_frame_end();
        do begin
            @(posedge clk);
        end while (!progress_done_o);
        repeat (2) @(posedge clk);
    endtask

    task automatic run_test(input string name, input int f, input bit gapped);
        int err_before;
        int win_before;
        err_before = err_cnt;
        win_before = rd_idx;
        test_name  = name;
        send_frame(f, gapped);
        wait_frame_end();
        test_cnt++;
        $display("test %-16s windows %0d errors %0d", name, rd_idx - win_before,
                 err_cnt - err_before);
    endtask

    initial begin
        #(WATCHDOG_NS * 1ns);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        arst_n_i    = 1'b0;
        done_i      = 1'b0;
        grayscale_i = '0;
        closes_win  = 1'b0;
        closes_last = 1'b0;
        strobe_seen = 1'b0;
        const_frame = 1'b0;
        rd_idx      = 0;
        pulse_cnt   = 0;
        err_cnt     = 0;
        test_cnt    = 0;
        test_name   = "reset_quiet";
        void'($urandom(32'h5767_7672));

        // frame 1 repeats frame 0 and frame 2 is flat
        for (int r = 0; r < texture_pkg::ROWS; r++) begin
            for (int c = 0; c < texture_pkg::COLS; c++) begin
                img[0][r][c] = texture_pkg::PIX_W'($urandom);
                img[1][r][c] = img[0][r][c];
                img[2][r][c] = 8'h6b;
            end
        end
        for (int f = 0; f < 3; f++) begin
            for (int r = 1; r < texture_pkg::ROWS - 1; r++) begin
                for (int c = 1; c < texture_pkg::COLS - 1; c++) begin
                    exp_lbp_q.push_back(lbp_ref(f, r, c));
                    exp_ni_q.push_back(ni_ref(f, r, c));
                end
            end
        end
        exp_lbp = exp_lbp_q[0];
        exp_ni  = exp_ni_q[0];

        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (6) @(posedge clk);
        test_cnt++;
        $display("test %-16s windows 0 errors %0d", test_name, err_cnt);

        run_test("random_b2b", 0, 1'b0);
        run_test("random_gapped", 1, 1'b1);
        const_frame = 1'b1;
        run_test("constant_image", 2, 1'b0);

        if (rd_idx != exp_lbp_q.size()) begin
            err_cnt++;
            $display("only %0d of %0d windows came out", rd_idx, exp_lbp_q.size());
        end
        $display("summary: %0d tests, %0d windows, %0d errors", test_cnt, rd_idx, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== design/texture_top.sv ====
module texture_top (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic [texture_pkg::PIX_W-1:0]  grayscale_i,
    input  logic                           done_i,
    output logic [texture_pkg::CODE_W-1:0] lbp_code_o,
    output logic [texture_pkg::CODE_W-1:0] ni_code_o,
    output logic                           done_o,
    output logic                           progress_done_o
);

    // 3x3 taps, row major from the top left
    logic [texture_pkg::PIX_W-1:0] s1, s2, s3;
    logic [texture_pkg::PIX_W-1:0] s4, s5, s6;
    logic [texture_pkg::PIX_W-1:0] s7, s8, s9;
    logic                          win_done;
    logic                          win_last;

    window_3x3 u_window (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .done_i     (done_i),
        .pix_i      (grayscale_i),
        .s1_o       (s1),
        .s2_o       (s2),
        .s3_o       (s3),
        .s4_o       (s4),
        .s5_o       (s5),
        .s6_o       (s6),
        .s7_o       (s7),
        .s8_o       (s8),
        .s9_o       (s9),
        .win_done_o (win_done),
        .win_last_o (win_last)
    );

    lbp_code u_lbp (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .win_done_i (win_done),
        .s1_i       (s1),
        .s2_i       (s2),
        .s3_i       (s3),
        .s4_i       (s4),
        .s5_i       (s5),
        .s6_i       (s6),
        .s7_i       (s7),
        .s8_i       (s8),
        .s9_i       (s9),
        .lbp_code_o (lbp_code_o)
    );

    // also owns the output strobes, same latency as the lbp register
    ni_code u_ni (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .win_done_i      (win_done),
        .win_last_i      (win_last),
        .s1_i            (s1),
        .s2_i            (s2),
        .s3_i            (s3),
        .s4_i            (s4),
        .s5_i            (s5),
        .s6_i            (s6),
        .s7_i            (s7),
        .s8_i            (s8),
        .s9_i            (s9),
        .ni_code_o       (ni_code_o),
        .done_o          (done_o),
        .progress_done_o (progress_done_o)
    );

endmodule

// ==== design/ni_code.sv ====
module ni_code (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           win_done_i,
    input  logic                           win_last_i,
    input  logic [texture_pkg::PIX_W-1:0]  s1_i,
    input  logic [texture_pkg::PIX_W-1:0]  s2_i,
    input  logic [texture_pkg::PIX_W-1:0]  s3_i,
    input  logic [texture_pkg::PIX_W-1:0]  s4_i,
    input  logic [texture_pkg::PIX_W-1:0]  s5_i,
    input  logic [texture_pkg::PIX_W-1:0]  s6_i,
    input  logic [texture_pkg::PIX_W-1:0]  s7_i,
    input  logic [texture_pkg::PIX_W-1:0]  s8_i,
    input  logic [texture_pkg::PIX_W-1:0]  s9_i,
    output logic [texture_pkg::CODE_W-1:0] ni_code_o,
    output logic                           done_o,
    output logic                           progress_done_o
);

    // neighbors in code bit order, counterclockwise from east
    logic [texture_pkg::PIX_W-1:0]  nbr [texture_pkg::CODE_W];
    logic [texture_pkg::SUM_W-1:0]  patch_sum;
    logic [texture_pkg::CODE_W-1:0] code_next;

    // zero extend a pixel to sum width
    function automatic logic [texture_pkg::SUM_W-1:0] widen(
        input logic [texture_pkg::PIX_W-1:0] p
    );
        logic [texture_pkg::SUM_W-1:0] w;
        w = '0;
        w[texture_pkg::PIX_W-1:0] = p;
        return w;
    endfunction

    assign nbr[0] = s6_i;
    assign nbr[1] = s3_i;
    assign nbr[2] = s2_i;
    assign nbr[3] = s1_i;
    assign nbr[4] = s4_i;
    assign nbr[5] = s7_i;
    assign nbr[6] = s8_i;
    assign nbr[7] = s9_i;

    // center plus the eight neighbors
    always_comb begin
        patch_sum = widen(s5_i);
        for (int b = 0; b < texture_pkg::CODE_W; b++) begin
            patch_sum = patch_sum + widen(nbr[b]);
        end
    end

    // n >= sum / 9 rewritten as 9n >= sum, 9n as 8n + n
    always_comb begin
        for (int b = 0; b < texture_pkg::CODE_W; b++) begin
            code_next[b] = ((widen(nbr[b]) << 3) + widen(nbr[b])) >= patch_sum;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ni_code_o <= '0;
        end else if (win_done_i) begin
            ni_code_o <= code_next;
        end
    end

    // strobes follow the window every cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_o          <= 1'b0;
            progress_done_o <= 1'b0;
        end else begin
            done_o          <= win_done_i;
            progress_done_o <= win_done_i && win_last_i;
        end
    end

endmodule

// ==== design/lbp_code.sv ====
module lbp_code (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           win_done_i,
    input  logic [texture_pkg::PIX_W-1:0]  s1_i,
    input  logic [texture_pkg::PIX_W-1:0]  s2_i,
    input  logic [texture_pkg::PIX_W-1:0]  s3_i,
    input  logic [texture_pkg::PIX_W-1:0]  s4_i,
    input  logic [texture_pkg::PIX_W-1:0]  s5_i,
    input  logic [texture_pkg::PIX_W-1:0]  s6_i,
    input  logic [texture_pkg::PIX_W-1:0]  s7_i,
    input  logic [texture_pkg::PIX_W-1:0]  s8_i,
    input  logic [texture_pkg::PIX_W-1:0]  s9_i,
    output logic [texture_pkg::CODE_W-1:0] lbp_code_o
);

    // neighbors in code bit order, counterclockwise from east
    logic [texture_pkg::PIX_W-1:0]  nbr [texture_pkg::CODE_W];
    logic [texture_pkg::CODE_W-1:0] code_next;

    assign nbr[0] = s6_i;
    assign nbr[1] = s3_i;
    assign nbr[2] = s2_i;
    assign nbr[3] = s1_i;
    assign nbr[4] = s4_i;
    assign nbr[5] = s7_i;
    assign nbr[6] = s8_i;
    assign nbr[7] = s9_i;

    // threshold against the center pixel
    always_comb begin
        for (int b = 0; b < texture_pkg::CODE_W; b++) begin
            code_next[b] = (nbr[b] >= s5_i);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lbp_code_o <= '0;
        end else if (win_done_i) begin
            lbp_code_o <= code_next;
        end
    end

endmodule

// ==== design/window/window_3x3.sv ====
module window_3x3 (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          done_i,
    input  logic [texture_pkg::PIX_W-1:0] pix_i,
    output logic [texture_pkg::PIX_W-1:0] s1_o,
    output logic [texture_pkg::PIX_W-1:0] s2_o,
    output logic [texture_pkg::PIX_W-1:0] s3_o,
    output logic [texture_pkg::PIX_W-1:0] s4_o,
    output logic [texture_pkg::PIX_W-1:0] s5_o,
    output logic [texture_pkg::PIX_W-1:0] s6_o,
    output logic [texture_pkg::PIX_W-1:0] s7_o,
    output logic [texture_pkg::PIX_W-1:0] s8_o,
    output logic [texture_pkg::PIX_W-1:0] s9_o,
    output logic                          win_done_o,
    output logic                          win_last_o
);

    logic [texture_pkg::COL_W-1:0] col_cnt;
    logic [texture_pkg::ROW_W-1:0] row_cnt;
    logic                          col_end;
    logic                          row_end;
    logic                          win_ok;

    logic [texture_pkg::PIX_W-1:0] mid_pix;
    logic [texture_pkg::PIX_W-1:0] top_pix;

    // window columns, left is the oldest
    logic [texture_pkg::PIX_W-1:0] top_l, top_c, top_r;
    logic [texture_pkg::PIX_W-1:0] mid_l, mid_c, mid_r;
    logic [texture_pkg::PIX_W-1:0] bot_l, bot_c, bot_r;

    row_buffer u_rows (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_i     (done_i),
        .col_i    (col_cnt),
        .pix_i    (pix_i),
        .mid_o    (mid_pix),
        .top_o    (top_pix)
    );

    assign col_end = (col_cnt == texture_pkg::COL_W'(texture_pkg::COLS - 1));
    assign row_end = (row_cnt == texture_pkg::ROW_W'(texture_pkg::ROWS - 1));

    // the incoming pixel closes a full 3x3 patch
    assign win_ok = (col_cnt >= texture_pkg::COL_W'(2)) &&
                    (row_cnt >= texture_pkg::ROW_W'(2));

    // raster position, wraps at frame end
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (done_i) begin
            if (col_end) begin
                col_cnt <= '0;
                row_cnt <= row_end ? '0 : row_cnt + texture_pkg::ROW_W'(1);
            end else begin
                col_cnt <= col_cnt + texture_pkg::COL_W'(1);
            end
        end
    end

    // strobes line up with the shifted window
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            win_done_o <= 1'b0;
            win_last_o <= 1'b0;
        end else begin
            win_done_o <= done_i && win_ok;
            win_last_o <= done_i && col_end && row_end;
        end
    end

    // shift one column per pixel
    always_ff @(posedge clk) begin
        if (done_i) begin
            top_l <= top_c;
            top_c <= top_r;
            top_r <= top_pix;
            mid_l <= mid_c;
            mid_c <= mid_r;
            mid_r <= mid_pix;
            bot_l <= bot_c;
            bot_c <= bot_r;
            bot_r <= pix_i;
        end
    end

    assign s1_o = top_l;
    assign s2_o = top_c;
    assign s3_o = top_r;
    assign s4_o = mid_l;
    assign s5_o = mid_c;
    assign s6_o = mid_r;
    assign s7_o = bot_l;
    assign s8_o = bot_c;
    assign s9_o = bot_r;

endmodule

// ==== design/window/row_buffer.sv ====
module row_buffer (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          wr_i,
    input  logic [texture_pkg::COL_W-1:0] col_i,
    input  logic [texture_pkg::PIX_W-1:0] pix_i,
    output logic [texture_pkg::PIX_W-1:0] mid_o,
    output logic [texture_pkg::PIX_W-1:0] top_o
);

    // one row ago
    logic [texture_pkg::PIX_W-1:0] mid_mem [texture_pkg::COLS];
    // two rows ago
    logic [texture_pkg::PIX_W-1:0] top_mem [texture_pkg::COLS];

    // history of the addressed column, read without a clock
    assign mid_o = mid_mem[col_i];
    assign top_o = top_mem[col_i];

    // a write ages the column by one row
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < texture_pkg::COLS; i++) begin
                mid_mem[i] <= '0;
                top_mem[i] <= '0;
            end
        end else if (wr_i) begin
            top_mem[col_i] <= mid_mem[col_i];
            mid_mem[col_i] <= pix_i;
        end
    end

endmodule

// ==== common/texture_pkg.sv ====
package texture_pkg;

    // grayscale pixel, one byte
    localparam int PIX_W = 8;

    // fixed frame geometry
    localparam int COLS = 30;
    localparam int ROWS = 30;

    // raster position counters
    localparam int COL_W = $clog2(COLS);
    localparam int ROW_W = $clog2(ROWS);

    // one bit per neighbor of a 3x3 window
    localparam int CODE_W = 8;

    // sum of nine pixels, max 9 * 255 = 2295
    // also holds nine times a single pixel
    localparam int SUM_W = 12;

endpackage
